//--- verilog/frame_pkg.sv
`default_nettype none

package frame_pkg;

    //////////////////////////////////////////////////////////////////////
    // Protocol constants
    //////////////////////////////////////////////////////////////////////

    localparam logic [15:0] ETHER_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_PROTOCOL_UDP = 8'd17;

    localparam int MAC_HEADER_BYTES  = 14;
    localparam int IPV4_HEADER_BYTES = 20;
    localparam int UDP_HEADER_BYTES  = 8;
    localparam int FCS_BYTES         = 4;

    // Shorter IPv4 packets are padded up to the Ethernet minimum
    localparam int MIN_IPV4_TOTAL_LENGTH = 46;

    //////////////////////////////////////////////////////////////////////
    // Shared types
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic       start;
        logic [7:0] value;
    } rx_byte_t;

    typedef struct packed {
        logic [15:0] ether_type;
        logic [15:0] ipv4_total_length;
        logic [15:0] ipv4_identification;
        logic [15:0] ipv4_flags;
        logic [7:0]  ipv4_protocol;
        logic [15:0] udp_destination;
    } header_info_t;

    typedef enum logic [2:0] {
        phase_idle,
        phase_mac_header,
        phase_ipv4_header,
        phase_udp_header,
        phase_payload,
        phase_pad,
        phase_fcs,
        phase_drop
    } frame_phase_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } payload_byte_t;

endpackage

`default_nettype wire

//--- verilog/frame_sequencer.sv
`default_nettype none

module frame_sequencer #(
    parameter int RECEIVE_SLOTS = 4
) (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire frame_pkg::rx_byte_t     rx_byte,
    input  wire                          rx_enable,
    input  wire [RECEIVE_SLOTS-1:0]      slot_enable,
    input  wire frame_pkg::header_info_t header_info,
    output frame_pkg::frame_phase_t      phase,
    output logic [15:0]                  byte_offset,
    output logic                         frame_start,
    output logic                         frame_end,
    output logic                         frame_abort
);

    frame_pkg::frame_phase_t state;
    frame_pkg::frame_phase_t next_state;
    frame_pkg::frame_phase_t tail_phase;
    logic [15:0]             section_count;
    logic [15:0]             next_count;
    logic [15:0]             payload_bytes;
    logic [15:0]             pad_bytes;
    logic                    frame_active;
    logic                    ether_reject;
    logic                    ip_reject;

    // Section lengths from the captured total length
    assign payload_bytes = header_info.ipv4_total_length
        - 16'(frame_pkg::IPV4_HEADER_BYTES + frame_pkg::UDP_HEADER_BYTES);
    assign pad_bytes =
        (header_info.ipv4_total_length < 16'(frame_pkg::MIN_IPV4_TOTAL_LENGTH))
        ? 16'(frame_pkg::MIN_IPV4_TOTAL_LENGTH) - header_info.ipv4_total_length
        : 16'd0;
    assign tail_phase = (pad_bytes != 16'd0) ? frame_pkg::phase_pad : frame_pkg::phase_fcs;

    assign frame_active = (state != frame_pkg::phase_idle) && (state != frame_pkg::phase_drop);

    // Filter conditions
    assign ether_reject = header_info.ether_type != frame_pkg::ETHER_TYPE_IPV4;
    assign ip_reject    = (header_info.ipv4_protocol != frame_pkg::IP_PROTOCOL_UDP)
                       || (header_info.ipv4_flags[12:0] != 13'd0);

    //////////////////////////////////////////////////////////////////////
    // Section of the current byte and the next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        phase       = state;
        byte_offset = section_count;
        frame_start = 1'b0;
        frame_end   = 1'b0;
        frame_abort = 1'b0;
        next_state  = state;
        next_count  = section_count;

        if (rx_enable) begin
            if (rx_byte.start) begin
                // New frame cuts off whatever was in progress
                frame_abort = frame_active;
                byte_offset = 16'd0;
                if (|slot_enable) begin
                    phase       = frame_pkg::phase_mac_header;
                    frame_start = 1'b1;
                end
                else begin
                    phase = frame_pkg::phase_drop;
                end
            end
            else if (state == frame_pkg::phase_ipv4_header && section_count == 16'd0
                     && ether_reject) begin
                phase = frame_pkg::phase_drop;
            end
            else if (state == frame_pkg::phase_udp_header && section_count == 16'd0
                     && ip_reject) begin
                phase = frame_pkg::phase_drop;
            end

            next_state = phase;
            next_count = byte_offset + 16'd1;

            case (phase)
                frame_pkg::phase_mac_header: begin
                    if (byte_offset == 16'(frame_pkg::MAC_HEADER_BYTES - 1)) begin
                        next_state = frame_pkg::phase_ipv4_header;
                        next_count = 16'd0;
                    end
                end
                frame_pkg::phase_ipv4_header: begin
                    if (byte_offset == 16'(frame_pkg::IPV4_HEADER_BYTES - 1)) begin
                        next_state = frame_pkg::phase_udp_header;
                        next_count = 16'd0;
                    end
                end
                frame_pkg::phase_udp_header: begin
                    if (byte_offset == 16'(frame_pkg::UDP_HEADER_BYTES - 1)) begin
                        next_state = (payload_bytes != 16'd0) ? frame_pkg::phase_payload
                                                              : tail_phase;
                        next_count = 16'd0;
                    end
                end
                frame_pkg::phase_payload: begin
                    if (byte_offset == payload_bytes - 16'd1) begin
                        next_state = tail_phase;
                        next_count = 16'd0;
                    end
                end
                frame_pkg::phase_pad: begin
                    if (byte_offset == pad_bytes - 16'd1) begin
                        next_state = frame_pkg::phase_fcs;
                        next_count = 16'd0;
                    end
                end
                frame_pkg::phase_fcs: begin
                    if (byte_offset == 16'(frame_pkg::FCS_BYTES - 1)) begin
                        frame_end  = 1'b1;
                        next_state = frame_pkg::phase_idle;
                        next_count = 16'd0;
                    end
                end
                default: begin
                    next_count = 16'd0;
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state         <= frame_pkg::phase_idle;
            section_count <= 16'd0;
        end
        else begin
            state         <= next_state;
            section_count <= next_count;
        end
    end

endmodule

`default_nettype wire

//--- verilog/header_capture.sv
`default_nettype none

module header_capture (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire frame_pkg::rx_byte_t     rx_byte,
    input  wire                          rx_enable,
    input  wire frame_pkg::frame_phase_t phase,
    input  wire [15:0]                   byte_offset,
    output frame_pkg::header_info_t      header_info
);

    // Fields are big endian on the wire, so shift in from the low byte
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            header_info <= '0;
        end
        else if (rx_enable) begin
            case (phase)
                frame_pkg::phase_mac_header: begin
                    // EtherType is the last two MAC header bytes
                    if (byte_offset >= 16'd12) begin
                        header_info.ether_type <= {header_info.ether_type[7:0], rx_byte.value};
                    end
                end
                frame_pkg::phase_ipv4_header: begin
                    case (byte_offset)
                        16'd2, 16'd3: begin
                            header_info.ipv4_total_length <=
                                {header_info.ipv4_total_length[7:0], rx_byte.value};
                        end
                        16'd4, 16'd5: begin
                            header_info.ipv4_identification <=
                                {header_info.ipv4_identification[7:0], rx_byte.value};
                        end
                        16'd6, 16'd7: begin
                            header_info.ipv4_flags <=
                                {header_info.ipv4_flags[7:0], rx_byte.value};
                        end
                        16'd9: begin
                            header_info.ipv4_protocol <= rx_byte.value;
                        end
                        default: begin
                        end
                    endcase
                end
                frame_pkg::phase_udp_header: begin
                    if (byte_offset == 16'd2 || byte_offset == 16'd3) begin
                        header_info.udp_destination <=
                            {header_info.udp_destination[7:0], rx_byte.value};
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/fcs_checker.sv
`default_nettype none

module fcs_checker (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire frame_pkg::rx_byte_t     rx_byte,
    input  wire                          rx_enable,
    input  wire frame_pkg::frame_phase_t phase,
    input  wire                          frame_start,
    input  wire                          frame_end,
    output logic                         fcs_ok
);

    // Reflected form of the Ethernet polynomial
    localparam logic [31:0] CRC_POLYNOMIAL = 32'hEDB8_8320;

    logic [31:0] crc;
    logic [31:0] crc_seed;
    logic [31:0] fcs_shift;
    logic [31:0] received_fcs;
    logic        crc_byte;

    function automatic logic [31:0] crc_update(input logic [31:0] crc_in,
                                               input logic [7:0]  data);
        logic [31:0] c;
        c = crc_in ^ {24'd0, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLYNOMIAL) : (c >> 1);
        end
        return c;
    endfunction

    assign crc_seed = frame_start ? 32'hFFFF_FFFF : crc;
    assign crc_byte = rx_enable
                   && (phase == frame_pkg::phase_mac_header
                    || phase == frame_pkg::phase_ipv4_header
                    || phase == frame_pkg::phase_udp_header
                    || phase == frame_pkg::phase_payload
                    || phase == frame_pkg::phase_pad);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            crc <= 32'hFFFF_FFFF;
        end
        else if (crc_byte) begin
            crc <= crc_update(crc_seed, rx_byte.value);
        end
    end

    // FCS arrives least significant byte first
    always_ff @(posedge clock) begin
        if (rx_enable && phase == frame_pkg::phase_fcs) begin
            fcs_shift <= {rx_byte.value, fcs_shift[31:8]};
        end
    end

    assign received_fcs = {rx_byte.value, fcs_shift[31:8]};
    assign fcs_ok       = frame_end && (received_fcs == ~crc);

endmodule

`default_nettype wire

//--- verilog/slot_dispatch.sv
`default_nettype none

module slot_dispatch #(
    parameter int RECEIVE_SLOTS = 4
) (
    input  wire                          clock,
    input  wire                          reset_n,
    input  wire frame_pkg::rx_byte_t     rx_byte,
    input  wire                          rx_enable,
    input  wire frame_pkg::frame_phase_t phase,
    input  wire [RECEIVE_SLOTS-1:0]      slot_enable,
    input  wire                          frame_start,
    input  wire                          frame_end,
    input  wire                          frame_abort,
    input  wire                          fcs_ok,
    output frame_pkg::payload_byte_t     packet_byte,
    output logic [RECEIVE_SLOTS-1:0]     packet_valid,
    output logic [RECEIVE_SLOTS-1:0]     good_packet,
    output logic [RECEIVE_SLOTS-1:0]     bad_packet
);

    logic [RECEIVE_SLOTS-1:0] slot_mask;
    logic [RECEIVE_SLOTS-1:0] highest_slot;
    logic                     forward;
    logic                     byte_valid;
    logic [7:0]               byte_data;

    // Highest enabled slot as a one-hot mask
    always_comb begin
        highest_slot = '0;
        for (int i = 0; i < RECEIVE_SLOTS; i++) begin
            if (slot_enable[i]) begin
                highest_slot    = '0;
                highest_slot[i] = 1'b1;
            end
        end
    end

    assign forward = rx_enable
                  && (phase == frame_pkg::phase_udp_header || phase == frame_pkg::phase_payload);

    // Abort and the next start share a cycle, old mask still in place
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            slot_mask    <= '0;
            byte_valid   <= 1'b0;
            packet_valid <= '0;
            good_packet  <= '0;
            bad_packet   <= '0;
        end
        else begin
            if (frame_start) begin
                slot_mask <= highest_slot;
            end
            byte_valid   <= forward;
            packet_valid <= forward ? slot_mask : '0;
            good_packet  <= (frame_end && fcs_ok) ? slot_mask : '0;
            bad_packet   <= ((frame_end && !fcs_ok) || frame_abort) ? slot_mask : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (forward) begin
            byte_data <= rx_byte.value;
        end
    end

    assign packet_byte = '{data: byte_data, valid: byte_valid};

endmodule

`default_nettype wire

//--- verilog/frame_parser.sv
`default_nettype none

module frame_parser #(
    parameter int RECEIVE_SLOTS = 4
) (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire frame_pkg::rx_byte_t rx_byte,
    input  wire                      rx_enable,
    input  wire [RECEIVE_SLOTS-1:0]  slot_enable,
    output frame_pkg::payload_byte_t packet_byte,
    output logic [RECEIVE_SLOTS-1:0] packet_valid,
    output logic [RECEIVE_SLOTS-1:0] good_packet,
    output logic [RECEIVE_SLOTS-1:0] bad_packet,
    output frame_pkg::header_info_t  header_info
);

    frame_pkg::frame_phase_t phase;
    logic [15:0]             byte_offset;
    logic                    frame_start;
    logic                    frame_end;
    logic                    frame_abort;
    logic                    fcs_ok;

    //////////////////////////////////////////////////////////////////////
    // Byte stream pipeline
    //////////////////////////////////////////////////////////////////////

    frame_sequencer #(
        .RECEIVE_SLOTS (RECEIVE_SLOTS)
    ) i_frame_sequencer (
        .clock       (clock),
        .reset_n     (reset_n),
        .rx_byte     (rx_byte),
        .rx_enable   (rx_enable),
        .slot_enable (slot_enable),
        .header_info (header_info),
        .phase       (phase),
        .byte_offset (byte_offset),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .frame_abort (frame_abort)
    );

    header_capture i_header_capture (
        .clock       (clock),
        .reset_n     (reset_n),
        .rx_byte     (rx_byte),
        .rx_enable   (rx_enable),
        .phase       (phase),
        .byte_offset (byte_offset),
        .header_info (header_info)
    );

    fcs_checker i_fcs_checker (
        .clock       (clock),
        .reset_n     (reset_n),
        .rx_byte     (rx_byte),
        .rx_enable   (rx_enable),
        .phase       (phase),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .fcs_ok      (fcs_ok)
    );

    slot_dispatch #(
        .RECEIVE_SLOTS (RECEIVE_SLOTS)
    ) i_slot_dispatch (
        .clock        (clock),
        .reset_n      (reset_n),
        .rx_byte      (rx_byte),
        .rx_enable    (rx_enable),
        .phase        (phase),
        .slot_enable  (slot_enable),
        .frame_start  (frame_start),
        .frame_end    (frame_end),
        .frame_abort  (frame_abort),
        .fcs_ok       (fcs_ok),
        .packet_byte  (packet_byte),
        .packet_valid (packet_valid),
        .good_packet  (good_packet),
        .bad_packet   (bad_packet)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Reset held low for the first 16 rising edges
    initial begin
        reset_n = 1'b0;
        repeat (16) @(posedge clock);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/tb_frame_parser.sv
`default_nettype none

module tb_frame_parser;

    localparam int RECEIVE_SLOTS = 4;
    localparam int TABLE_ROWS    = 10;

    localparam logic [2:0] KIND_UDP      = 3'd0;
    localparam logic [2:0] KIND_NOT_IPV4 = 3'd1;
    localparam logic [2:0] KIND_NOT_UDP  = 3'd2;
    localparam logic [2:0] KIND_FRAGMENT = 3'd3;
    localparam logic [2:0] KIND_CUT      = 3'd4;

    typedef struct packed {
        logic [2:0]               kind;
        logic [15:0]              payload_length;
        logic [RECEIVE_SLOTS-1:0] slot_enable;
        logic [15:0]              udp_port;
        logic                     corrupt_fcs;
    } frame_row_t;

    typedef struct packed {
        logic [RECEIVE_SLOTS-1:0] slot_mask;
        logic [7:0]               data;
    } expected_byte_t;

    typedef struct packed {
        logic [RECEIVE_SLOTS-1:0] slot_mask;
        logic                     good;
        frame_pkg::header_info_t  header;
    } expected_status_t;

    // Kind, payload bytes, slot_enable, UDP destination, corrupt FCS
    localparam frame_row_t FRAME_TABLE [TABLE_ROWS] = '{
        '{KIND_UDP,      16'd30, 4'b1000, 16'h1388, 1'b0},
        '{KIND_UDP,      16'd5,  4'b0001, 16'h0035, 1'b0},
        '{KIND_UDP,      16'd12, 4'b0010, 16'h2000, 1'b1},
        '{KIND_NOT_IPV4, 16'd20, 4'b1000, 16'h0101, 1'b0},
        '{KIND_NOT_UDP,  16'd20, 4'b1000, 16'h0102, 1'b0},
        '{KIND_FRAGMENT, 16'd20, 4'b0001, 16'h0103, 1'b0},
        '{KIND_UDP,      16'd20, 4'b0000, 16'h0104, 1'b0},
        '{KIND_CUT,      16'd24, 4'b0100, 16'h4242, 1'b0},
        '{KIND_UDP,      16'd16, 4'b0010, 16'h7777, 1'b0},
        '{KIND_UDP,      16'd10, 4'b0110, 16'hbeef, 1'b0}
    };

    logic                     clock;
    logic                     reset_n;
    frame_pkg::rx_byte_t      rx_byte;
    logic                     rx_enable;
    logic [RECEIVE_SLOTS-1:0] slot_enable;
    frame_pkg::payload_byte_t packet_byte;
    logic [RECEIVE_SLOTS-1:0] packet_valid;
    logic [RECEIVE_SLOTS-1:0] good_packet;
    logic [RECEIVE_SLOTS-1:0] bad_packet;
    frame_pkg::header_info_t  header_info;

    logic [7:0]       frame_bytes [$];
    expected_byte_t   expected_bytes [$];
    expected_status_t expected_status [$];
    expected_byte_t   next_byte;
    expected_status_t next_status;
    integer           seed;
    int               cycle_count = 0;
    int               cycle_limit;

    tb_clock_gen i_tb_clock_gen (
        .clock   (clock),
        .reset_n (reset_n)
    );

    frame_parser #(
        .RECEIVE_SLOTS (RECEIVE_SLOTS)
    ) i_frame_parser (
        .clock        (clock),
        .reset_n      (reset_n),
        .rx_byte      (rx_byte),
        .rx_enable    (rx_enable),
        .slot_enable  (slot_enable),
        .packet_byte  (packet_byte),
        .packet_valid (packet_valid),
        .good_packet  (good_packet),
        .bad_packet   (bad_packet),
        .header_info  (header_info)
    );

    //////////////////////////////////////////////////////////////////////
    // Reference models
    //////////////////////////////////////////////////////////////////////

    // Ethernet CRC-32, one bit at a time, LSB of each byte first
    function automatic logic [31:0] next_crc(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc;
        for (int b = 0; b < 8; b++) begin
            if (c[0] ^ data[b]) begin
                c = {1'b0, c[31:1]} ^ 32'hedb8_8320;
            end
            else begin
                c = {1'b0, c[31:1]};
            end
        end
        return c;
    endfunction

    function automatic logic [RECEIVE_SLOTS-1:0] slot_mask_of(
        input logic [RECEIVE_SLOTS-1:0] enable
    );
        logic [RECEIVE_SLOTS-1:0] mask;
        mask = '0;
        for (int s = RECEIVE_SLOTS - 1; s >= 0; s--) begin
            if (enable[s] && mask == '0) begin
                mask[s] = 1'b1;
            end
        end
        return mask;
    endfunction

    function automatic int frame_length(input frame_row_t row);
        int ip_length;
        ip_length = 28 + int'(row.payload_length);
        return 14 + ((ip_length < 46) ? 46 : ip_length) + 4;
    endfunction

    task automatic push_word(input logic [15:0] word);
        frame_bytes.push_back(word[15:8]);
        frame_bytes.push_back(word[7:0]);
    endtask

    // Whole frame into frame_bytes, expectations into the two queues
    task automatic build_frame(input frame_row_t row);
        logic [15:0]              ip_length;
        logic [31:0]              crc;
        logic [31:0]              value;
        logic [RECEIVE_SLOTS-1:0] mask;
        logic                     forwarded;
        frame_pkg::header_info_t  header;
        int                       pad;
        int                       keep;
        ip_length = 16'd28 + row.payload_length;
        pad       = (ip_length < 16'd46) ? 46 - int'(ip_length) : 0;
        mask      = slot_mask_of(row.slot_enable);
        forwarded = (row.kind == KIND_UDP || row.kind == KIND_CUT) && mask != '0;
        header.ether_type          = (row.kind == KIND_NOT_IPV4) ? 16'h86dd : 16'h0800;
        header.ipv4_total_length   = ip_length;
        header.ipv4_identification = 16'h1c46;
        header.ipv4_flags          = (row.kind == KIND_FRAGMENT) ? 16'h2010 : 16'h4000;
        header.ipv4_protocol       = (row.kind == KIND_NOT_UDP) ? 8'd6 : 8'd17;
        header.udp_destination     = row.udp_port;
        frame_bytes.delete();
        for (int i = 0; i < 12; i++) begin
            frame_bytes.push_back(8'h10 + 8'(i));
        end
        push_word(header.ether_type);
        push_word(16'h4500);
        push_word(header.ipv4_total_length);
        push_word(header.ipv4_identification);
        push_word(header.ipv4_flags);
        push_word({8'h40, header.ipv4_protocol});
        push_word(16'h0000);
        push_word(16'hc0a8);
        push_word(16'h0001);
        push_word(16'hc0a8);
        push_word(16'h0002);
        push_word(16'h4000);
        push_word(header.udp_destination);
        push_word(16'd8 + row.payload_length);
        push_word(16'h0000);
        for (int p = 0; p < int'(row.payload_length); p++) begin
            value = $random(seed);
            frame_bytes.push_back(value[7:0]);
        end
        for (int p = 0; p < pad; p++) begin
            frame_bytes.push_back(8'h00);
        end
        crc = '1;
        foreach (frame_bytes[i]) begin
            crc = next_crc(crc, frame_bytes[i]);
        end
        crc = ~crc;
        if (row.corrupt_fcs) begin
            crc[5] = ~crc[5];
        end
        frame_bytes.push_back(crc[7:0]);
        frame_bytes.push_back(crc[15:8]);
        frame_bytes.push_back(crc[23:16]);
        frame_bytes.push_back(crc[31:24]);

        // Cut frames stop halfway through the payload
        keep = (row.kind == KIND_CUT) ? 42 + int'(row.payload_length) / 2
                                      : 42 + int'(row.payload_length);
        if (row.kind == KIND_CUT) begin
            while (frame_bytes.size() > keep) begin
                void'(frame_bytes.pop_back());
            end
        end
        if (forwarded) begin
            for (int i = 34; i < keep; i++) begin
                expected_bytes.push_back('{slot_mask: mask, data: frame_bytes[i]});
            end
            expected_status.push_back('{slot_mask: mask,
                                        good: !(row.corrupt_fcs || row.kind == KIND_CUT),
                                        header: header});
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    task automatic report_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            report_failure();
        end
    endtask

    always @(negedge clock) begin
        if (!reset_n) begin
            check_value("packet_valid", 32'(packet_valid), 32'd0);
            check_value("good_packet", 32'(good_packet), 32'd0);
            check_value("bad_packet", 32'(bad_packet), 32'd0);
        end
        else begin
            if (packet_valid != '0 || packet_byte.valid) begin
                if (expected_bytes.size() == 0) begin
                    $display("Unexpected byte on packet_byte at time %0t", $time);
                    report_failure();
                end
                else begin
                    next_byte = expected_bytes.pop_front();
                    check_value("packet_valid", 32'(packet_valid), 32'(next_byte.slot_mask));
                    check_value("packet_byte.valid", 32'(packet_byte.valid), 32'd1);
                    check_value("packet_byte.data", 32'(packet_byte.data), 32'(next_byte.data));
                end
            end
            if ((good_packet | bad_packet) != '0) begin
                if (expected_status.size() == 0) begin
                    $display("Unexpected good or bad pulse at time %0t", $time);
                    report_failure();
                end
                else begin
                    next_status = expected_status.pop_front();
                    check_value("good_packet", 32'(good_packet),
                                next_status.good ? 32'(next_status.slot_mask) : 32'd0);
                    check_value("bad_packet", 32'(bad_packet),
                                next_status.good ? 32'd0 : 32'(next_status.slot_mask));
                    check_value("header_info.ether_type",
                                32'(header_info.ether_type),
                                32'(next_status.header.ether_type));
                    check_value("header_info.ipv4_total_length",
                                32'(header_info.ipv4_total_length),
                                32'(next_status.header.ipv4_total_length));
                    check_value("header_info.ipv4_identification",
                                32'(header_info.ipv4_identification),
                                32'(next_status.header.ipv4_identification));
                    check_value("header_info.ipv4_flags",
                                32'(header_info.ipv4_flags),
                                32'(next_status.header.ipv4_flags));
                    check_value("header_info.ipv4_protocol",
                                32'(header_info.ipv4_protocol),
                                32'(next_status.header.ipv4_protocol));
                    check_value("header_info.udp_destination",
                                32'(header_info.udp_destination),
                                32'(next_status.header.udp_destination));
                end
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            report_failure();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        rx_byte     = '0;
        rx_enable   = 1'b0;
        slot_enable = '0;
        seed        = 32'ha185;
        cycle_limit = 200;
        for (int r = 0; r < TABLE_ROWS; r++) begin
            cycle_limit = cycle_limit + frame_length(FRAME_TABLE[r]);
        end
        wait (reset_n === 1'b1);
        for (int r = 0; r < TABLE_ROWS; r++) begin
            build_frame(FRAME_TABLE[r]);
            for (int i = 0; i < frame_bytes.size(); i++) begin
                // One idle cycle inside the UDP header stretches the frame
                if (i == 40) begin
                    @(posedge clock);
                    rx_enable <= 1'b0;
                end
                @(posedge clock);
                rx_byte     <= '{start: (i == 0), value: frame_bytes[i]};
                rx_enable   <= 1'b1;
                slot_enable <= FRAME_TABLE[r].slot_enable;
            end
            // Cut frame runs straight into the next start byte
            if (FRAME_TABLE[r].kind != KIND_CUT) begin
                repeat (2) begin
                    @(posedge clock);
                    rx_enable <= 1'b0;
                end
            end
        end
        repeat (4) @(posedge clock);
        if (expected_bytes.size() != 0 || expected_status.size() != 0) begin
            $display("Run ended with %0d bytes and %0d status pulses never seen",
                     expected_bytes.size(), expected_status.size());
            report_failure();
        end
        else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/frame_pkg.sv
verilog/frame_sequencer.sv
verilog/header_capture.sv
verilog/fcs_checker.sv
verilog/slot_dispatch.sv
verilog/frame_parser.sv
verif/tb_clock_gen.sv
verif/tb_frame_parser.sv

//--- Makefile
TOP = tb_frame_parser

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f vlog.f --Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
